// File: design/zx_ports_pkg.sv
// port addresses, extended register numbers, reset values and port select enum
`default_nettype none

package zx_ports_pkg;

	// bus widths
	localparam int ADDR_W = 16;
	localparam int DATA_W = 8;

	// low byte of the port address
	localparam logic [7:0] PORT_FE    = 8'hFE; // keyboard, tape
	localparam logic [7:0] PORT_FD    = 8'hFD; // 7FFD paging when a15 is clear
	localparam logic [7:0] PORT_XT    = 8'hAF; // extended config, reg number in high byte
	localparam logic [7:0] PORT_KJOY  = 8'h1F; // kempston joystick
	localparam logic [7:0] PORT_MOUSE = 8'hDF; // kempston mouse
	localparam logic [7:0] PORT_SDCFG = 8'h77; // sd chip select
	localparam logic [7:0] PORT_SDDAT = 8'h57; // sd spi data

	// extended register numbers, high byte of an AF access
	localparam logic [7:0] XT_XSTAT   = 8'h00; // status, power-up bit
	localparam logic [7:0] XT_RAMPAGE = 8'h10; // 10..13
	localparam logic [7:0] XT_FMADDR  = 8'h15;
	localparam logic [7:0] XT_SYSCONF = 8'h20;
	localparam logic [7:0] XT_MEMCONF = 8'h21;
	localparam logic [7:0] XT_IM2VECT = 8'h25;

	// register values after reset
	localparam logic [DATA_W-1:0] RST_MEMCONF  = 8'h04; // no rom map
	localparam logic [DATA_W-1:0] RST_IM2VECT  = 8'hFF;
	localparam logic [DATA_W-1:0] RST_RAMPAGE0 = 8'h00;
	localparam logic [DATA_W-1:0] RST_RAMPAGE1 = 8'h05;
	localparam logic [DATA_W-1:0] RST_RAMPAGE2 = 8'h02;
	localparam logic [DATA_W-1:0] RST_RAMPAGE3 = 8'h00;

	// decoded port of the current access
	typedef enum logic [3:0]
	{
		SEL_NONE,
		SEL_FE,
		SEL_7FFD,
		SEL_XT,
		SEL_KJOY,
		SEL_MOUSE,
		SEL_SDCFG,
		SEL_SDDAT
	} port_sel_e;

endpackage

`default_nettype wire

// File: design/io_access_if.sv
// io_access_if: one latched port access with slave, decoder, reader and client modports
`timescale 1ns/1ps
`default_nettype none

interface io_access_if;

	logic                              stb;   // one cycle per access
	logic                              wr;
	logic [zx_ports_pkg::ADDR_W-1:0]   addr;
	logic [zx_ports_pkg::DATA_W-1:0]   wdata;
	zx_ports_pkg::port_sel_e           sel;
	logic [zx_ports_pkg::DATA_W-1:0]   rdata;

	modport slave   (output stb, wr, addr, wdata, input rdata);
	modport decoder (input addr, output sel);
	modport reader  (input stb, wr, addr, sel, output rdata);
	modport client  (input stb, wr, addr, wdata, sel);

endinterface

`default_nettype wire

// File: design/io_bus_slave.sv
// io_bus_slave: four-phase req/ack handshake, request latching and access strobe
`timescale 1ns/1ps
`default_nettype none

module io_bus_slave
(
	input  wire                               clk,
	input  wire                               rst,

	input  wire                               io_req,
	input  wire                               io_wr,
	input  wire [zx_ports_pkg::ADDR_W-1:0]    io_addr,
	input  wire [zx_ports_pkg::DATA_W-1:0]    io_wdata,
	output logic                              io_ack,
	output logic [zx_ports_pkg::DATA_W-1:0]   io_rdata,

	io_access_if.slave                        acc
);

	// handshake phases
	localparam logic [1:0] PH_IDLE    = 2'd0;
	localparam logic [1:0] PH_STROBE  = 2'd1; // registers update at the end of this cycle
	localparam logic [1:0] PH_ACK     = 2'd2; // ack goes out on the next edge
	localparam logic [1:0] PH_RELEASE = 2'd3; // wait for req to drop

	logic [1:0] phase;

	assign acc.stb = (phase == PH_STROBE);

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			phase  <= PH_IDLE;
			io_ack <= 1'b0;
		end
		else
		begin
			case (phase)
			PH_IDLE:
				if (io_req)
					phase <= PH_STROBE;
			PH_STROBE:
				phase <= PH_ACK;
			PH_ACK:
			begin
				io_ack <= 1'b1;
				phase  <= PH_RELEASE;
			end
			default:
				if (!io_req)
				begin
					io_ack <= 1'b0; // master released, back to idle
					phase  <= PH_IDLE;
				end
			endcase
		end
	end

	// request fields and read data, held for the whole access
	always_ff @(posedge clk)
	begin
		if (phase == PH_IDLE && io_req)
		begin
			acc.wr    <= io_wr;
			acc.addr  <= io_addr;
			acc.wdata <= io_wdata;
		end
		if (phase == PH_STROBE)
			io_rdata <= acc.rdata; // same edge as register update
	end

endmodule

`default_nettype wire

// File: design/port_decoder.sv
// port_decoder: latched address and dos flag to port select
`timescale 1ns/1ps
`default_nettype none

module port_decoder
(
	input  wire             dos,
	io_access_if.decoder    acc
);

	logic [7:0] loa;
	logic [7:0] hoa;

	assign loa = acc.addr[7:0];
	assign hoa = acc.addr[zx_ports_pkg::ADDR_W-1:8];

	always_comb
	begin
		acc.sel = zx_ports_pkg::SEL_NONE;
		case (loa)
		zx_ports_pkg::PORT_FE:
			acc.sel = zx_ports_pkg::SEL_FE;
		zx_ports_pkg::PORT_FD:
			if (!hoa[7]) // 7FFD only, xFFD is the AY
				acc.sel = zx_ports_pkg::SEL_7FFD;
		zx_ports_pkg::PORT_XT:
			acc.sel = zx_ports_pkg::SEL_XT;
		zx_ports_pkg::PORT_KJOY:
			// same address as the fdc command port inside dos
			if (!dos)
				acc.sel = zx_ports_pkg::SEL_KJOY;
		zx_ports_pkg::PORT_MOUSE:
			acc.sel = zx_ports_pkg::SEL_MOUSE;
		zx_ports_pkg::PORT_SDCFG:
			if (!dos)
				acc.sel = zx_ports_pkg::SEL_SDCFG;
		zx_ports_pkg::PORT_SDDAT:
			if (!dos)
				acc.sel = zx_ports_pkg::SEL_SDDAT;
		default:
			acc.sel = zx_ports_pkg::SEL_NONE;
		endcase
	end

endmodule

`default_nettype wire

// File: design/xt_config_regs.sv
// xt_config_regs: extended config registers and 7FFD paging with 48K and 128K locks
`timescale 1ns/1ps
`default_nettype none

module xt_config_regs
#(
	parameter logic [zx_ports_pkg::DATA_W-1:0] RESET_SYSCONF = 8'h01 // turbo 7 MHz
)
(
	input  wire                               clk,
	input  wire                               rst,

	io_access_if.client                       acc,

	output logic [4*zx_ports_pkg::DATA_W-1:0] xt_page,
	output logic [4:0]                        fmaddr,
	output logic [zx_ports_pkg::DATA_W-1:0]   sysconf,
	output logic [zx_ports_pkg::DATA_W-1:0]   memconf,
	output logic [zx_ports_pkg::DATA_W-1:0]   im2vect
);

	logic [zx_ports_pkg::DATA_W-1:0] rampage [0:3];
	logic [7:0]                      hoa;
	logic                            lock48;   // set by 7FFD bit 5, only reset clears it
	logic                            lock128;
	logic                            xt_wr;
	logic                            p7ffd_wr;

	assign hoa     = acc.addr[zx_ports_pkg::ADDR_W-1:8];
	assign lock128 = memconf[6];

	assign xt_wr    = acc.stb && acc.wr && (acc.sel == zx_ports_pkg::SEL_XT);
	assign p7ffd_wr = acc.stb && acc.wr && (acc.sel == zx_ports_pkg::SEL_7FFD) && !lock48;

	assign xt_page = {rampage[3], rampage[2], rampage[1], rampage[0]};

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			lock48     <= 1'b0;
			fmaddr[4]  <= 1'b0; // fm off, low bits keep their value
			sysconf    <= RESET_SYSCONF;
			memconf    <= zx_ports_pkg::RST_MEMCONF;
			im2vect    <= zx_ports_pkg::RST_IM2VECT;
			rampage[0] <= zx_ports_pkg::RST_RAMPAGE0;
			rampage[1] <= zx_ports_pkg::RST_RAMPAGE1;
			rampage[2] <= zx_ports_pkg::RST_RAMPAGE2;
			rampage[3] <= zx_ports_pkg::RST_RAMPAGE3;
		end
		else if (p7ffd_wr)
		begin
			memconf[0] <= acc.wdata[4];            // rom select
			rampage[3] <= {3'b000, lock128 ? 2'b00 : acc.wdata[7:6], acc.wdata[2:0]};
			lock48     <= acc.wdata[5];
		end
		else if (xt_wr)
		begin
			if (hoa[7:2] == zx_ports_pkg::XT_RAMPAGE[7:2])
				rampage[hoa[1:0]] <= acc.wdata;
			case (hoa)
			zx_ports_pkg::XT_FMADDR:
				fmaddr <= acc.wdata[4:0];
			zx_ports_pkg::XT_SYSCONF:
				sysconf <= acc.wdata;
			zx_ports_pkg::XT_MEMCONF:
				memconf <= acc.wdata;
			zx_ports_pkg::XT_IM2VECT:
				im2vect <= acc.wdata;
			default:
				; // unknown numbers are ignored
			endcase
		end
	end

endmodule

`default_nettype wire

// File: design/sd_card_port.sv
// sd_card_port: sd chip select register and spi start and data control
`timescale 1ns/1ps
`default_nettype none

module sd_card_port
(
	input  wire                               clk,
	input  wire                               rst,

	io_access_if.client                       acc,

	output logic                              sdcs_n,
	output logic                              sd_start,
	output logic [zx_ports_pkg::DATA_W-1:0]   sd_datain
);

	logic sdcfg_wr;

	assign sdcfg_wr = acc.stb && acc.wr && (acc.sel == zx_ports_pkg::SEL_SDCFG);

	always_ff @(posedge clk)
	begin
		if (rst)
			sdcs_n <= 1'b1; // card deselected
		else if (sdcfg_wr)
			sdcs_n <= acc.wdata[1];
	end

	// any data port access kicks one spi byte
	assign sd_start  = acc.stb && (acc.sel == zx_ports_pkg::SEL_SDDAT);
	// a read shifts out ones
	assign sd_datain = acc.wr ? acc.wdata : 8'hFF;

endmodule

`default_nettype wire

// File: design/port_read_mux.sv
// port_read_mux: read data selection and the one-shot power-up status bit
`timescale 1ns/1ps
`default_nettype none

module port_read_mux
(
	input  wire                               clk,
	input  wire                               rst,

	io_access_if.reader                       acc,

	input  wire [4*zx_ports_pkg::DATA_W-1:0]  xt_page,
	input  wire                               tape_read,
	input  wire [4:0]                         keys_in,
	input  wire [4:0]                         kj_in,
	input  wire [7:0]                         mus_in,
	input  wire [zx_ports_pkg::DATA_W-1:0]    sd_dataout
);

	logic [7:0] hoa;
	logic       pwr_up;
	logic       xstat_rd;

	assign hoa      = acc.addr[zx_ports_pkg::ADDR_W-1:8];
	assign xstat_rd = acc.stb && !acc.wr && (acc.sel == zx_ports_pkg::SEL_XT)
		&& (hoa == zx_ports_pkg::XT_XSTAT);

	// the slave captures rdata at this same edge, so the first read still sees 1
	always_ff @(posedge clk)
	begin
		if (rst)
			pwr_up <= 1'b1;
		else if (xstat_rd)
			pwr_up <= 1'b0;
	end

	always_comb
	begin
		case (acc.sel)
		zx_ports_pkg::SEL_FE:
			acc.rdata = {1'b1, tape_read, 1'b0, keys_in};
		zx_ports_pkg::SEL_KJOY:
			acc.rdata = {3'b000, kj_in};
		zx_ports_pkg::SEL_MOUSE:
			acc.rdata = mus_in;
		zx_ports_pkg::SEL_SDCFG:
			acc.rdata = 8'h00; // card present, not write protected
		zx_ports_pkg::SEL_SDDAT:
			acc.rdata = sd_dataout;
		zx_ports_pkg::SEL_XT:
			if (hoa == zx_ports_pkg::XT_XSTAT)
				acc.rdata = {1'b0, pwr_up, 6'b000000};
			else if (hoa[7:2] == zx_ports_pkg::XT_RAMPAGE[7:2])
				acc.rdata = xt_page[{hoa[1:0], 3'b000} +: 8];
			else
				acc.rdata = 8'hFF;
		default:
			acc.rdata = 8'hFF; // 7FFD is write only
		endcase
	end

endmodule

`default_nettype wire

// File: design/zx_ports_top.sv
// zx_ports_top: port block top level with plain bus and status ports
`timescale 1ns/1ps
`default_nettype none

module zx_ports_top
#(
	parameter logic [zx_ports_pkg::DATA_W-1:0] RESET_SYSCONF = 8'h01
)
(
	input  wire                               clk,
	input  wire                               rst,

	// bus master
	input  wire                               io_req,
	input  wire                               io_wr,
	input  wire [zx_ports_pkg::ADDR_W-1:0]    io_addr,
	input  wire [zx_ports_pkg::DATA_W-1:0]    io_wdata,
	output logic                              io_ack,
	output logic [zx_ports_pkg::DATA_W-1:0]   io_rdata,

	// status inputs
	input  wire                               dos,
	input  wire [4:0]                         keys_in,
	input  wire                               tape_read,
	input  wire [4:0]                         kj_in,
	input  wire [7:0]                         mus_in,
	input  wire [zx_ports_pkg::DATA_W-1:0]    sd_dataout,

	// configuration and sd control
	output logic [4*zx_ports_pkg::DATA_W-1:0] xt_page,
	output logic [4:0]                        fmaddr,
	output logic [zx_ports_pkg::DATA_W-1:0]   sysconf,
	output logic [zx_ports_pkg::DATA_W-1:0]   memconf,
	output logic [zx_ports_pkg::DATA_W-1:0]   im2vect,
	output logic                              sdcs_n,
	output logic                              sd_start,
	output logic [zx_ports_pkg::DATA_W-1:0]   sd_datain
);

	io_access_if acc ();

	io_bus_slave u_slave (.clk(clk), .rst(rst), .io_req(io_req), .io_wr(io_wr),
		.io_addr(io_addr), .io_wdata(io_wdata), .io_ack(io_ack), .io_rdata(io_rdata),
		.acc(acc.slave));

	port_decoder u_decoder (.dos(dos), .acc(acc.decoder));

	xt_config_regs #(.RESET_SYSCONF(RESET_SYSCONF)) u_xt_regs (.clk(clk), .rst(rst),
		.acc(acc.client), .xt_page(xt_page), .fmaddr(fmaddr), .sysconf(sysconf),
		.memconf(memconf), .im2vect(im2vect));

	sd_card_port u_sd (.clk(clk), .rst(rst), .acc(acc.client), .sdcs_n(sdcs_n),
		.sd_start(sd_start), .sd_datain(sd_datain));

	port_read_mux u_rmux (.clk(clk), .rst(rst), .acc(acc.reader), .xt_page(xt_page),
		.tape_read(tape_read), .keys_in(keys_in), .kj_in(kj_in), .mus_in(mus_in),
		.sd_dataout(sd_dataout));

endmodule

`default_nettype wire

// File: include/tb_ports_model.svh
// register model state, model reset and write and read prediction for the port testbench
`ifndef TB_PORTS_MODEL_SVH
`define TB_PORTS_MODEL_SVH
`default_nettype none

logic [7:0] m_page [0:3];
logic [4:0] m_fmaddr;
logic       m_fm_valid; // low fm bits unknown until the first write
logic [7:0] m_sysconf;
logic [7:0] m_memconf;
logic [7:0] m_im2vect;
logic       m_lock48;
logic       m_pwr_up;
logic       m_sdcs_n;

task automatic reset_model();
	m_page[0] = zx_ports_pkg::RST_RAMPAGE0;
	m_page[1] = zx_ports_pkg::RST_RAMPAGE1;
	m_page[2] = zx_ports_pkg::RST_RAMPAGE2;
	m_page[3] = zx_ports_pkg::RST_RAMPAGE3;
	m_fmaddr = 5'b00000;
	m_fm_valid = 1'b0;
	m_sysconf = SYSCONF_INIT;
	m_memconf = zx_ports_pkg::RST_MEMCONF;
	m_im2vect = zx_ports_pkg::RST_IM2VECT;
	m_lock48 = 1'b0;
	m_pwr_up = 1'b1;
	m_sdcs_n = 1'b1; // card deselected
endtask

task automatic predict_write(input logic [15:0] addr, input logic [7:0] d, input logic in_dos);
	logic [7:0] lo;
	logic [7:0] hi;
	lo = addr[7:0];
	hi = addr[15:8];
	if (lo == zx_ports_pkg::PORT_FD && !addr[15])
	begin
		if (!m_lock48)
		begin
			m_page[3] = {3'b000, m_memconf[6] ? 2'b00 : d[7:6], d[2:0]}; // 128K lock masks 7:6
			m_memconf[0] = d[4];
			m_lock48 = d[5];
		end
	end
	else if (lo == zx_ports_pkg::PORT_XT)
	begin
		if (hi >= zx_ports_pkg::XT_RAMPAGE && hi <= zx_ports_pkg::XT_RAMPAGE + 8'd3)
			m_page[2'(hi - zx_ports_pkg::XT_RAMPAGE)] = d;
		else if (hi == zx_ports_pkg::XT_FMADDR)
		begin
			m_fmaddr = d[4:0];
			m_fm_valid = 1'b1;
		end
		else if (hi == zx_ports_pkg::XT_SYSCONF)
			m_sysconf = d;
		else if (hi == zx_ports_pkg::XT_MEMCONF)
			m_memconf = d;
		else if (hi == zx_ports_pkg::XT_IM2VECT)
			m_im2vect = d;
	end
	else if (lo == zx_ports_pkg::PORT_SDCFG && !in_dos)
		m_sdcs_n = d[1];
endtask

// expected read byte from the current input levels
task automatic predict_read(input logic [15:0] addr, input logic in_dos, output logic [7:0] exp);
	logic [7:0] lo;
	logic [7:0] hi;
	lo = addr[7:0];
	hi = addr[15:8];
	exp = 8'hFF;
	if (lo == zx_ports_pkg::PORT_FE)
		exp = {1'b1, tape_read, 1'b0, keys_in};
	else if (lo == zx_ports_pkg::PORT_KJOY && !in_dos)
		exp = {3'b000, kj_in};
	else if (lo == zx_ports_pkg::PORT_MOUSE)
		exp = mus_in;
	else if (lo == zx_ports_pkg::PORT_SDCFG && !in_dos)
		exp = 8'h00;
	else if (lo == zx_ports_pkg::PORT_SDDAT && !in_dos)
		exp = sd_dataout;
	else if (lo == zx_ports_pkg::PORT_XT)
	begin
		if (hi == zx_ports_pkg::XT_XSTAT)
		begin
			exp = m_pwr_up ? 8'h40 : 8'h00;
			m_pwr_up = 1'b0; // one shot
		end
		else if (hi >= zx_ports_pkg::XT_RAMPAGE && hi <= zx_ports_pkg::XT_RAMPAGE + 8'd3)
			exp = m_page[2'(hi - zx_ports_pkg::XT_RAMPAGE)];
	end
endtask

`default_nettype wire
`endif

// File: bench/tb_zx_ports.sv
// clock, reset, lfsr stimulus, handshake driver, checks and final verdict for the port block
`timescale 1ns/1ps
`default_nettype none

module tb_zx_ports;

	localparam logic [7:0] SYSCONF_INIT = 8'h03; // differs from the rtl default
	localparam int         ACK_TIMEOUT  = 20; // cycles per handshake wait

	logic        clk = 1'b0;
	logic        rst;
	logic        io_req;
	logic        io_wr;
	logic [15:0] io_addr;
	logic [7:0]  io_wdata;
	logic        io_ack;
	logic [7:0]  io_rdata;
	logic        dos;
	logic [4:0]  keys_in;
	logic        tape_read;
	logic [4:0]  kj_in;
	logic [7:0]  mus_in;
	logic [7:0]  sd_dataout;
	logic [31:0] xt_page;
	logic [4:0]  fmaddr;
	logic [7:0]  sysconf;
	logic [7:0]  memconf;
	logic [7:0]  im2vect;
	logic        sdcs_n;
	logic        sd_start;
	logic [7:0]  sd_datain;
	logic [31:0] lfsr_state;

	`include "tb_ports_model.svh"

	zx_ports_top #(.RESET_SYSCONF(SYSCONF_INIT)) dut (.*);

	always #2 clk = ~clk;

	// galois lfsr stepped once per bit
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		int          i;
		v = 32'h0;
		for (i = 0; i < n; i++)
		begin
			if (lfsr_state[0])
				lfsr_state = (lfsr_state >> 1) ^ 32'h8020_0003;
			else
				lfsr_state = lfsr_state >> 1;
			v = {v[30:0], lfsr_state[0]};
		end
		return v;
	endfunction

	function automatic logic [7:0] pick_xt_reg();
		logic [3:0] idx;
		idx = 4'(rand_bits(4));
		case (idx)
		4'd0: return zx_ports_pkg::XT_XSTAT;
		4'd1: return 8'h10;
		4'd2: return 8'h11;
		4'd3: return 8'h12;
		4'd4: return 8'h13;
		4'd5: return zx_ports_pkg::XT_FMADDR;
		4'd6: return zx_ports_pkg::XT_SYSCONF;
		4'd7: return zx_ports_pkg::XT_MEMCONF;
		4'd8: return zx_ports_pkg::XT_IM2VECT;
		default: return 8'(rand_bits(8)); // mostly unknown numbers
		endcase
	endfunction

	function automatic logic [7:0] pick_port();
		logic [2:0] idx;
		idx = 3'(rand_bits(3));
		case (idx)
		3'd0: return zx_ports_pkg::PORT_FE;
		3'd1: return zx_ports_pkg::PORT_KJOY;
		3'd2: return zx_ports_pkg::PORT_MOUSE;
		3'd3: return zx_ports_pkg::PORT_SDCFG;
		3'd4: return zx_ports_pkg::PORT_SDDAT;
		3'd5: return zx_ports_pkg::PORT_XT;
		3'd6: return zx_ports_pkg::PORT_FD;
		default: return 8'(rand_bits(8));
		endcase
	endfunction

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("SOME TESTS FAILED");
		$fatal(1, "run stopped at the first failure");
	endtask

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp)
			abort_run($sformatf("ERROR %s got %h expected %h", name, got, exp));
	endtask

	task automatic compare_outputs();
		check("xt_page", xt_page, {m_page[3], m_page[2], m_page[1], m_page[0]});
		check("sysconf", 32'(sysconf), 32'(m_sysconf));
		check("memconf", 32'(memconf), 32'(m_memconf));
		check("im2vect", 32'(im2vect), 32'(m_im2vect));
		check("sdcs_n", 32'(sdcs_n), 32'(m_sdcs_n));
		check("fmaddr[4]", 32'(fmaddr[4]), 32'(m_fmaddr[4]));
		if (m_fm_valid)
			check("fmaddr", 32'(fmaddr), 32'(m_fmaddr));
	endtask

	task automatic apply_reset();
		@(posedge clk);
		rst <= 1'b1;
		repeat (3) @(posedge clk);
		rst <= 1'b0;
		reset_model();
	endtask

	// one four-phase access and its checks against the model
	task automatic run_access(input logic wr, input logic [15:0] addr, input logic [7:0] data);
		int         cycles;
		int         pulses;
		logic [7:0] sd_seen;
		logic [7:0] got_rd;
		logic [7:0] exp_rd;
		logic       sd_hit;
		cycles = 0;
		pulses = 0;
		sd_seen = 8'h00;
		@(posedge clk);
		io_req <= 1'b1;
		io_wr <= wr;
		io_addr <= addr;
		io_wdata <= data;
		do
		begin
			@(negedge clk);
			cycles++;
			if (sd_start === 1'b1)
			begin
				pulses++;
				sd_seen = sd_datain;
			end
			if (cycles > ACK_TIMEOUT)
				abort_run("timeout waiting for io_ack to rise after io_req");
		end while (io_ack !== 1'b1);
		// ack two edges after req is sampled and seen at the following negedge
		check("io_ack latency", 32'(cycles), 32'd4);
		got_rd = io_rdata;
		@(posedge clk);
		io_req <= 1'b0;
		cycles = 0;
		do
		begin
			@(negedge clk);
			cycles++;
			if (cycles > ACK_TIMEOUT)
				abort_run("timeout waiting for io_ack to fall after io_req dropped");
		end while (io_ack !== 1'b0);
		check("io_ack release", 32'(cycles), 32'd2);
		sd_hit = (addr[7:0] == zx_ports_pkg::PORT_SDDAT) && !dos;
		check("sd_start pulses", 32'(pulses), sd_hit ? 32'd1 : 32'd0);
		if (sd_hit)
			check("sd_datain", 32'(sd_seen), wr ? 32'(data) : 32'hFF);
		if (wr)
			predict_write(addr, data, dos);
		else
		begin
			predict_read(addr, dos, exp_rd);
			check("io_rdata", 32'(got_rd), 32'(exp_rd));
		end
		compare_outputs();
	endtask

	initial
	begin
		int          n;
		logic [7:0]  data;
		logic [15:0] addr;
		lfsr_state = 32'ha25f_eb8b;
		rst <= 1'b0;
		io_req <= 1'b0;
		io_wr <= 1'b0;
		io_addr <= 16'h0000;
		io_wdata <= 8'h00;
		dos <= 1'b0;
		keys_in <= 5'h1F;
		tape_read <= 1'b0;
		kj_in <= 5'h00;
		mus_in <= 8'hFF;
		sd_dataout <= 8'hFF;
		apply_reset();
		compare_outputs();
		run_access(1'b0, {zx_ports_pkg::XT_XSTAT, zx_ports_pkg::PORT_XT}, 8'h00); // 40
		run_access(1'b0, {zx_ports_pkg::XT_XSTAT, zx_ports_pkg::PORT_XT}, 8'h00); // now 00

		for (n = 0; n < 300; n++)
			run_access(1'(rand_bits(1)), {pick_xt_reg(), zx_ports_pkg::PORT_XT},
				8'(rand_bits(8)));

		for (n = 0; n < 200; n++)
		begin
			if (n % 50 == 49)
				apply_reset(); // only reset clears the 48K lock
			if (rand_bits(2) == 32'd0)
				run_access(1'b1, {zx_ports_pkg::XT_MEMCONF, zx_ports_pkg::PORT_XT},
					8'(rand_bits(8)));
			data = 8'(rand_bits(8));
			if (rand_bits(3) != 32'd0)
				data[5] = 1'b0;
			addr = {rand_bits(3) == 32'd0, 7'(rand_bits(7)), zx_ports_pkg::PORT_FD};
			run_access(1'b1, addr, data);
		end

		for (n = 0; n < 300; n++)
		begin
			@(posedge clk);
			dos <= 1'(rand_bits(1));
			keys_in <= 5'(rand_bits(5));
			tape_read <= 1'(rand_bits(1));
			kj_in <= 5'(rand_bits(5));
			mus_in <= 8'(rand_bits(8));
			sd_dataout <= 8'(rand_bits(8));
			run_access(1'b0, {8'(rand_bits(8)), pick_port()}, 8'h00);
		end

		for (n = 0; n < 150; n++)
		begin
			@(posedge clk);
			dos <= 1'(rand_bits(1));
			addr[15:8] = 8'(rand_bits(8));
			if (rand_bits(1) == 32'd1)
				addr[7:0] = zx_ports_pkg::PORT_SDCFG;
			else
				addr[7:0] = zx_ports_pkg::PORT_SDDAT;
			run_access(1'(rand_bits(1)), addr, 8'(rand_bits(8)));
		end

		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// File: all.f
+incdir+include
design/zx_ports_pkg.sv
design/io_access_if.sv
design/io_bus_slave.sv
design/port_decoder.sv
design/xt_config_regs.sv
design/sd_card_port.sv
design/port_read_mux.sv
design/zx_ports_top.sv
bench/tb_zx_ports.sv

// File: Makefile
# verilator build and run of the port block testbench

LOG := sim.log

.PHONY: help test clean

help:
	@echo "make test   build with verilator, run tb_zx_ports, search $(LOG) for the pass line"
	@echo "make clean  remove obj_dir and $(LOG)"
	@echo "make help   show this list"

test:
	verilator --binary --timing --timescale 1ns/1ps -f all.f --top-module tb_zx_ports -Mdir obj_dir
	obj_dir/Vtb_zx_ports | tee $(LOG)
	grep -q "^ALL TESTS PASSED$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
